//--- include/mips_exec_defs.svh
`ifndef MIPS_EXEC_DEFS_SVH
`define MIPS_EXEC_DEFS_SVH

// APB address and data widths.
`define MX_ADDR_W 8
`define MX_DATA_W 32

// Address map.
`define MX_ISSUE_ADDR  8'h00
`define MX_STATUS_ADDR 8'h04

// Register r lives at MX_REG_BASE + 4*r.
`define MX_REG_BASE    8'h80

`endif

//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Main opcode field.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // SPECIAL funct field.
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } rfields_t;

    // Lower half is either R-type fields or the 16-bit immediate.
    typedef union packed {
        rfields_t    r;
        logic [15:0] imm16;
    } low_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        low_t       low;
    } fields_t;

endpackage

`default_nettype wire

//--- hw/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_funct_e;

    typedef enum logic {ALU_SRCA_RS, ALU_SRCA_NCARE} srca_e;

    typedef enum logic [2:0] {
        ALU_SRCB_RT, ALU_SRCB_SIGN_IMMED, ALU_SRCB_IMMED, ALU_SRCB_UP_IMMED, ALU_SRCB_SHAMT
    } srcb_e;

    typedef enum logic [1:0] {DEST_REG_RT, DEST_REG_RD, DEST_REG_NCARE} dest_reg_e;
    typedef enum logic {REG_SRC_ALU, REG_SRC_FLAG} reg_src_e;
    typedef enum logic [1:0] {FLAG_LT, FLAG_LTU, FLAG_NCARE} flag_e;
    typedef enum logic [1:0] {EXC_CHK_NONE, EXC_CHK_OVERFLOW, EXC_CHK_RESERVED} exc_chk_e;

    typedef struct packed {
        alu_funct_e alu_funct;
        srca_e      alu_srca;
        srcb_e      alu_srcb;
        dest_reg_e  dest_reg;
        reg_src_e   reg_src;
        flag_e      flag_sel;
        exc_chk_e   exc_chk;
        logic       write_reg;
    } control_t;

    // Don't-care word both decoders start from.
    localparam control_t CTL_DEFAULT = '{
        alu_funct: ALU_ADD,        alu_srca: ALU_SRCA_NCARE, alu_srcb: ALU_SRCB_RT,
        dest_reg:  DEST_REG_NCARE, reg_src:  REG_SRC_ALU,    flag_sel: FLAG_NCARE,
        exc_chk:   EXC_CHK_NONE,   write_reg: 1'b0
    };

    typedef struct packed {
        isa_pkg::fields_t fields;
        logic [31:0]      instr;
    } dec_stage_t;

    typedef struct packed {
        logic        write_en;
        logic [4:0]  dest;
        logic [31:0] data;
        logic        reserved_hit;
        logic        overflow_hit;
    } wb_stage_t;

endpackage

`default_nettype wire

//--- hw/rtype_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rtype_decoder (
    input  isa_pkg::fields_t   instr,
    output ctrl_pkg::control_t ctl
);

    always_comb begin
        ctl           = ctrl_pkg::CTL_DEFAULT;
        ctl.alu_srca  = ctrl_pkg::ALU_SRCA_RS;
        ctl.alu_srcb  = ctrl_pkg::ALU_SRCB_RT;
        ctl.dest_reg  = ctrl_pkg::DEST_REG_RD;
        ctl.write_reg = 1'b1;
        case (instr.low.r.funct)
            isa_pkg::FN_ADDU: ctl.alu_funct = ctrl_pkg::ALU_ADD;
            isa_pkg::FN_SUBU: ctl.alu_funct = ctrl_pkg::ALU_SUB;
            isa_pkg::FN_AND:  ctl.alu_funct = ctrl_pkg::ALU_AND;
            isa_pkg::FN_OR:   ctl.alu_funct = ctrl_pkg::ALU_OR;
            isa_pkg::FN_XOR:  ctl.alu_funct = ctrl_pkg::ALU_XOR;
            isa_pkg::FN_NOR:  ctl.alu_funct = ctrl_pkg::ALU_NOR;
            isa_pkg::FN_SLT, isa_pkg::FN_SLTU: begin
                ctl.reg_src  = ctrl_pkg::REG_SRC_FLAG;
                ctl.flag_sel = (instr.low.r.funct == isa_pkg::FN_SLT) ?
                               ctrl_pkg::FLAG_LT : ctrl_pkg::FLAG_LTU;
            end
            isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA: begin
                // Shifts act on rt by the amount in shamt.
                ctl.alu_srca = ctrl_pkg::ALU_SRCA_NCARE;
                ctl.alu_srcb = ctrl_pkg::ALU_SRCB_SHAMT;
                case (instr.low.r.funct)
                    isa_pkg::FN_SLL: ctl.alu_funct = ctrl_pkg::ALU_SLL;
                    isa_pkg::FN_SRL: ctl.alu_funct = ctrl_pkg::ALU_SRL;
                    default:         ctl.alu_funct = ctrl_pkg::ALU_SRA;
                endcase
            end
            default: begin
                ctl.dest_reg  = ctrl_pkg::DEST_REG_NCARE;
                ctl.write_reg = 1'b0;
                ctl.exc_chk   = ctrl_pkg::EXC_CHK_RESERVED;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module main_decoder (
    input  isa_pkg::fields_t   instr,
    output ctrl_pkg::control_t ctl
);

    ctrl_pkg::control_t rtype_ctl;

    rtype_decoder rtype0 (
        .instr (instr),
        .ctl   (rtype_ctl)
    );

    always_comb begin
        ctl = ctrl_pkg::CTL_DEFAULT;
        case (instr.opcode)
            isa_pkg::OP_SPECIAL: ctl = rtype_ctl;

            isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU: begin
                ctl.alu_funct = ctrl_pkg::ALU_ADD;
                ctl.alu_srca  = ctrl_pkg::ALU_SRCA_RS;
                ctl.alu_srcb  = ctrl_pkg::ALU_SRCB_SIGN_IMMED;
                ctl.dest_reg  = ctrl_pkg::DEST_REG_RT;
                ctl.write_reg = 1'b1;
                // Only ADDI traps on signed overflow.
                if (instr.opcode == isa_pkg::OP_ADDI)
                    ctl.exc_chk = ctrl_pkg::EXC_CHK_OVERFLOW;
            end

            isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU: begin
                ctl.reg_src   = ctrl_pkg::REG_SRC_FLAG;
                ctl.alu_srca  = ctrl_pkg::ALU_SRCA_RS;
                ctl.alu_srcb  = ctrl_pkg::ALU_SRCB_SIGN_IMMED;
                ctl.dest_reg  = ctrl_pkg::DEST_REG_RT;
                ctl.write_reg = 1'b1;
                if (instr.opcode == isa_pkg::OP_SLTIU)
                    ctl.flag_sel = ctrl_pkg::FLAG_LTU;
                else
                    ctl.flag_sel = ctrl_pkg::FLAG_LT;
            end

            isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI: begin
                ctl.alu_srca  = ctrl_pkg::ALU_SRCA_RS;
                ctl.alu_srcb  = ctrl_pkg::ALU_SRCB_IMMED;
                ctl.dest_reg  = ctrl_pkg::DEST_REG_RT;
                ctl.write_reg = 1'b1;
                case (instr.opcode)
                    isa_pkg::OP_ANDI: ctl.alu_funct = ctrl_pkg::ALU_AND;
                    isa_pkg::OP_ORI:  ctl.alu_funct = ctrl_pkg::ALU_OR;
                    default:          ctl.alu_funct = ctrl_pkg::ALU_XOR;
                endcase
            end

            isa_pkg::OP_LUI: begin
                // Operand A reads as zero, so the sum is the shifted immediate.
                ctl.alu_funct = ctrl_pkg::ALU_ADD;
                ctl.alu_srca  = ctrl_pkg::ALU_SRCA_NCARE;
                ctl.alu_srcb  = ctrl_pkg::ALU_SRCB_UP_IMMED;
                ctl.dest_reg  = ctrl_pkg::DEST_REG_RT;
                ctl.write_reg = 1'b1;
            end

            default:
                ctl.exc_chk = ctrl_pkg::EXC_CHK_RESERVED;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  ctrl_pkg::control_t ctl,
    input  isa_pkg::fields_t   instr,
    input  logic [31:0]        rs_val,
    input  logic [31:0]        rt_val,
    output logic [31:0]        result,
    output logic               overflow
);

    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sum;
    logic [31:0] alu_out;
    logic        flag;

    always_comb begin
        a = (ctl.alu_srca == ctrl_pkg::ALU_SRCA_RS) ? rs_val : '0;
        case (ctl.alu_srcb)
            ctrl_pkg::ALU_SRCB_SIGN_IMMED: b = {{16{instr.low.imm16[15]}}, instr.low.imm16};
            ctrl_pkg::ALU_SRCB_IMMED:      b = {16'b0, instr.low.imm16};
            ctrl_pkg::ALU_SRCB_UP_IMMED:   b = {instr.low.imm16, 16'b0};
            ctrl_pkg::ALU_SRCB_SHAMT:      b = {27'b0, instr.low.r.shamt};
            default:                       b = rt_val;
        endcase
        sum = a + b;
        case (ctl.alu_funct)
            ctrl_pkg::ALU_SUB: alu_out = a - b;
            ctrl_pkg::ALU_AND: alu_out = a & b;
            ctrl_pkg::ALU_OR:  alu_out = a | b;
            ctrl_pkg::ALU_XOR: alu_out = a ^ b;
            ctrl_pkg::ALU_NOR: alu_out = ~(a | b);
            ctrl_pkg::ALU_SLL: alu_out = rt_val << b[4:0];
            ctrl_pkg::ALU_SRL: alu_out = rt_val >> b[4:0];
            ctrl_pkg::ALU_SRA: alu_out = $signed(rt_val) >>> b[4:0];
            default:           alu_out = sum;
        endcase
        case (ctl.flag_sel)
            ctrl_pkg::FLAG_LT:  flag = $signed(a) < $signed(b);
            ctrl_pkg::FLAG_LTU: flag = a < b;
            default:            flag = 1'b0;
        endcase
        result = (ctl.reg_src == ctrl_pkg::REG_SRC_FLAG) ? {31'b0, flag} : alu_out;
        // Same-sign operands with a result of the other sign.
        overflow = (ctl.exc_chk == ctrl_pkg::EXC_CHK_OVERFLOW) &&
                   (a[31] == b[31]) && (sum[31] != a[31]);
        assert (!overflow || ctl.alu_funct == ctrl_pkg::ALU_ADD)
            else $error("exec_alu: overflow flagged on a non-add operation");
    end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                pclk,
    input  logic                arst_n,
    input  logic [4:0]          rs_addr,
    input  logic [4:0]          rt_addr,
    input  logic [4:0]          rd_port_addr,
    output logic [31:0]         rs_val,
    output logic [31:0]         rt_val,
    output logic [31:0]         host_val,
    input  ctrl_pkg::wb_stage_t wb
);

    logic [31:0] regs [32];

    // $0 is never written, so it stays at its reset value.
    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb.write_en && wb.dest != 5'd0) begin
            regs[wb.dest] <= wb.data;
        end
    end

    assign rs_val   = regs[rs_addr];
    assign rt_val   = regs[rt_addr];
    assign host_val = regs[rd_port_addr];

endmodule

`default_nettype wire

//--- hw/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     pclk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge pclk) begin
        if (in_valid)
            out_data <= in_data;
    end

endmodule

`default_nettype wire

//--- hw/apb_host_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_exec_defs.svh"

module apb_host_port (
    input  logic                  pclk,
    input  logic                  arst_n,
    input  logic [`MX_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`MX_DATA_W-1:0] pwdata,
    output logic [`MX_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  issue_valid,
    output logic [31:0]           issue_instr,
    input  logic                  busy,
    input  ctrl_pkg::wb_stage_t   wb,
    input  logic                  wb_valid,
    output logic [4:0]            host_reg_addr,
    input  logic [31:0]           host_reg_val
);

    logic                  access;
    logic                  status_clr;
    logic [`MX_ADDR_W-1:0] reg_off;
    logic                  rsv_q;
    logic                  ovf_q;
    logic [15:0]           retired_q;

    assign access = psel && penable;

    // Writes never wait. Reads wait until the pipeline has drained.
    assign pready      = access && (pwrite || !busy);
    assign issue_valid = access && pwrite && (paddr == `MX_ISSUE_ADDR);
    assign issue_instr = pwdata;
    assign status_clr  = access && pwrite && (paddr == `MX_STATUS_ADDR);

    assign reg_off       = paddr - `MX_REG_BASE;
    assign host_reg_addr = reg_off[6:2];

    always_comb begin
        if (paddr == `MX_STATUS_ADDR)
            prdata = {retired_q, 14'b0, ovf_q, rsv_q};
        else if (paddr >= `MX_REG_BASE)
            prdata = host_reg_val;
        else
            prdata = '0;
    end

    // A retiring instruction still counts when it lands on a clear.
    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            rsv_q     <= 1'b0;
            ovf_q     <= 1'b0;
            retired_q <= '0;
        end else if (status_clr || wb_valid) begin
            rsv_q     <= (rsv_q && !status_clr) || (wb_valid && wb.reserved_hit);
            ovf_q     <= (ovf_q && !status_clr) || (wb_valid && wb.overflow_hit);
            retired_q <= (status_clr ? 16'd0 : retired_q) + {15'b0, wb_valid};
        end
    end

    // Back-to-back issues would read operands before the previous write-back.
    assert property (@(posedge pclk) disable iff (!arst_n) issue_valid |=> !issue_valid)
        else $error("apb_host_port: instructions issued on consecutive cycles");

endmodule

`default_nettype wire

//--- hw/mips_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_exec_defs.svh"

module mips_exec (
    input  logic                  pclk,
    input  logic                  arst_n,
    input  logic [`MX_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`MX_DATA_W-1:0] pwdata,
    output logic [`MX_DATA_W-1:0] prdata,
    output logic                  pready
);

    logic                 issue_valid;
    logic [31:0]          issue_instr;
    logic                 busy;
    ctrl_pkg::dec_stage_t dec_in;
    ctrl_pkg::dec_stage_t dec_q;
    logic                 dec_valid;
    ctrl_pkg::control_t   ctl;
    logic [31:0]          rs_val;
    logic [31:0]          rt_val;
    logic [31:0]          alu_result;
    logic                 alu_overflow;
    ctrl_pkg::wb_stage_t  wb_d;
    ctrl_pkg::wb_stage_t  wb_q;
    ctrl_pkg::wb_stage_t  wb_commit;
    logic                 wb_valid;
    logic [4:0]           host_reg_addr;
    logic [31:0]          host_reg_val;

    assign busy   = dec_valid || wb_valid;
    assign dec_in = '{fields: isa_pkg::fields_t'(issue_instr), instr: issue_instr};

    always_comb begin
        wb_d.write_en     = ctl.write_reg && !alu_overflow;
        wb_d.dest         = (ctl.dest_reg == ctrl_pkg::DEST_REG_RD) ?
                            dec_q.fields.low.r.rd : dec_q.fields.rt;
        wb_d.data         = alu_result;
        wb_d.reserved_hit = (ctl.exc_chk == ctrl_pkg::EXC_CHK_RESERVED);
        wb_d.overflow_hit = alu_overflow;
    end

    // Stage 2 data persists after its valid drops.
    always_comb begin
        wb_commit          = wb_q;
        wb_commit.write_en = wb_q.write_en && wb_valid;
    end

    apb_host_port port0 (
        .pclk          (pclk),
        .arst_n        (arst_n),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .issue_valid   (issue_valid),
        .issue_instr   (issue_instr),
        .busy          (busy),
        .wb            (wb_q),
        .wb_valid      (wb_valid),
        .host_reg_addr (host_reg_addr),
        .host_reg_val  (host_reg_val)
    );

    stage_reg #(.payload_t(ctrl_pkg::dec_stage_t)) dec_stage (
        .pclk      (pclk),
        .arst_n    (arst_n),
        .in_valid  (issue_valid),
        .in_data   (dec_in),
        .out_valid (dec_valid),
        .out_data  (dec_q)
    );

    main_decoder dec0 (
        .instr (dec_q.fields),
        .ctl   (ctl)
    );

    exec_alu alu0 (
        .ctl      (ctl),
        .instr    (dec_q.fields),
        .rs_val   (rs_val),
        .rt_val   (rt_val),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    stage_reg #(.payload_t(ctrl_pkg::wb_stage_t)) wb_stage (
        .pclk      (pclk),
        .arst_n    (arst_n),
        .in_valid  (dec_valid),
        .in_data   (wb_d),
        .out_valid (wb_valid),
        .out_data  (wb_q)
    );

    reg_file rf0 (
        .pclk         (pclk),
        .arst_n       (arst_n),
        .rs_addr      (dec_q.fields.rs),
        .rt_addr      (dec_q.fields.rt),
        .rd_port_addr (host_reg_addr),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .host_val     (host_reg_val),
        .wb           (wb_commit)
    );

endmodule

`default_nettype wire

//--- bench/tb_mips_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_exec_defs.svh"

module tb_mips_exec;

    localparam int HALF     = 20;
    localparam int QUARTER  = 10;
    localparam int MAX_WAIT = 50;

    // MIPS32 opcode and funct encodings.
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_SLTI  = 6'h0a;
    localparam logic [5:0] OPC_SLTIU = 6'h0b;
    localparam logic [5:0] OPC_ANDI  = 6'h0c;
    localparam logic [5:0] OPC_ORI   = 6'h0d;
    localparam logic [5:0] OPC_XORI  = 6'h0e;
    localparam logic [5:0] OPC_LUI   = 6'h0f;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] FN_SLL    = 6'h00;
    localparam logic [5:0] FN_SRL    = 6'h02;
    localparam logic [5:0] FN_SRA    = 6'h03;
    localparam logic [5:0] FN_ADDU   = 6'h21;
    localparam logic [5:0] FN_SUBU   = 6'h23;
    localparam logic [5:0] FN_AND    = 6'h24;
    localparam logic [5:0] FN_OR     = 6'h25;
    localparam logic [5:0] FN_XOR    = 6'h26;
    localparam logic [5:0] FN_NOR    = 6'h27;
    localparam logic [5:0] FN_SLT    = 6'h2a;
    localparam logic [5:0] FN_SLTU   = 6'h2b;

    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] got;
        logic [31:0] exp;
    } check_t;

    logic                  pclk;
    logic                  arst_n;
    logic [`MX_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`MX_DATA_W-1:0] pwdata;
    logic [`MX_DATA_W-1:0] prdata;
    logic                  pready;

    // Reference model state.
    logic [31:0] mregs [32];
    logic [15:0] m_retired;
    logic        m_ovf;
    logic        m_rsv;

    check_t      check_q [$];
    event        check_ev;
    logic        timed_out = 1'b0;
    integer      seed;
    int          errors;
    int          checks;
    int          tests_run;
    int          test_errs0;
    int          test_checks0;
    string       test_name;
    logic [5:0]  rfns [11];

    mips_exec dut0 (
        .pclk    (pclk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    initial begin
        pclk = 1'b0;
        forever #(HALF) pclk = ~pclk;
    end

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd,
                                               input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [7:0] reg_addr(input logic [4:0] r);
        return `MX_REG_BASE + {1'b0, r, 2'b00};
    endfunction

    // Executes one instruction on the model following the MIPS32 rules.
    function automatic void ref_exec(input logic [31:0] instr);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] res;
        logic [31:0] sum;
        logic [4:0]  sh;
        logic [4:0]  dst;
        logic        wr;
        a    = mregs[instr[25:21]];
        b    = mregs[instr[20:16]];
        sh   = instr[10:6];
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0000, instr[15:0]};
        dst  = instr[20:16];
        wr   = 1'b1;
        res  = '0;
        case (instr[31:26])
            6'h00: begin
                dst = instr[15:11];
                case (instr[5:0])
                    FN_SLL:  res = b << sh;
                    FN_SRL:  res = b >> sh;
                    FN_SRA:  res = $signed(b) >>> sh;
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                    FN_SLTU: res = {31'b0, a < b};
                    default: begin
                        wr    = 1'b0;
                        m_rsv = 1'b1;
                    end
                endcase
            end
            OPC_ADDI: begin
                sum = a + simm;
                res = sum;
                if (a[31] == simm[31] && sum[31] != a[31]) begin
                    wr    = 1'b0;
                    m_ovf = 1'b1;
                end
            end
            OPC_ADDIU: res = a + simm;
            OPC_SLTI:  res = {31'b0, $signed(a) < $signed(simm)};
            OPC_SLTIU: res = {31'b0, a < simm};
            OPC_ANDI:  res = a & zimm;
            OPC_ORI:   res = a | zimm;
            OPC_XORI:  res = a ^ zimm;
            OPC_LUI:   res = {instr[15:0], 16'h0000};
            default: begin
                wr    = 1'b0;
                m_rsv = 1'b1;
            end
        endcase
        if (wr && dst != 5'd0)
            mregs[dst] = res;
        m_retired = m_retired + 16'd1;
    endfunction

    // Runs one APB transfer, starting at a falling edge and ending on one.
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waits;
        waits   = 0;
        rdata   = '0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge pclk);
        penable = 1'b1;
        #(QUARTER);
        while (!pready && waits < MAX_WAIT) begin
            @(negedge pclk);
            #(QUARTER);
            waits++;
        end
        if (!pready) begin
            $display("Timeout: pready stayed low for %0d cycles at address 0x%02h", waits, addr);
            timed_out = 1'b1;
        end else begin
            rdata = prdata;
            // Writes complete in their first access cycle.
            if (wr) begin
                checks++;
                assert (waits == 0)
                    else begin
                        errors++;
                        $display("Error at %0t: write to address 0x%02h took %0d wait states",
                                 $time, addr, waits);
                    end
            end
            @(posedge pclk);
        end
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic issue_word(input logic [31:0] instr);
        apb_write(`MX_ISSUE_ADDR, instr);
        ref_exec(instr);
    endtask

    task automatic load_reg(input logic [4:0] r, input logic [31:0] val);
        issue_word(itype_word(OPC_LUI, 5'd0, r, val[31:16]));
        issue_word(itype_word(OPC_ORI, r, r, val[15:0]));
    endtask

    task automatic queue_check(input logic [7:0] addr, input logic [31:0] got,
                               input logic [31:0] exp);
        check_t c;
        c.addr = addr;
        c.got  = got;
        c.exp  = exp;
        if (!timed_out) begin
            check_q.push_back(c);
            -> check_ev;
        end
    endtask

    task automatic check_reg(input logic [4:0] r);
        logic [31:0] got;
        apb_read(reg_addr(r), got);
        queue_check(reg_addr(r), got, mregs[r]);
    endtask

    task automatic check_status();
        logic [31:0] got;
        apb_read(`MX_STATUS_ADDR, got);
        queue_check(`MX_STATUS_ADDR, got, {m_retired, 14'b0, m_ovf, m_rsv});
    endtask

    task automatic clear_status();
        apb_write(`MX_STATUS_ADDR, 32'h0);
        m_rsv     = 1'b0;
        m_ovf     = 1'b0;
        m_retired = 16'd0;
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        test_errs0   = errors;
        test_checks0 = checks;
    endtask

    task automatic report_test();
        // One idle cycle lets the compare process drain its queue.
        @(negedge pclk);
        tests_run++;
        $display("Test %0d %s: %0d checks, %0d errors", tests_run, test_name,
                 checks - test_checks0, errors - test_errs0);
    endtask

    initial begin
        check_t c;
        forever begin
            @(check_ev);
            while (check_q.size() > 0) begin
                c = check_q.pop_front();
                checks++;
                assert (c.got === c.exp)
                    else begin
                        errors++;
                        $display("Error at %0t: address 0x%02h read 0x%08h, expected 0x%08h",
                                 $time, c.addr, c.got, c.exp);
                    end
            end
        end
    end

    initial begin
        @(posedge timed_out);
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [31:0] a_pos;
        logic [31:0] a_neg;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  sh;
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        seed      = 32'he471;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        m_retired = 16'd0;
        m_ovf     = 1'b0;
        m_rsv     = 1'b0;
        for (int i = 0; i < 32; i++)
            mregs[i] = '0;
        rfns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                 FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
        repeat (2) @(posedge pclk);
        @(negedge pclk);
        arst_n = 1'b1;

        // Signed and unsigned compares disagree when the signs differ.
        start_test("immediate ops");
        a_pos = $random(seed) & 32'h7fff_ffff;
        a_neg = $random(seed) | 32'h8000_0000;
        load_reg(5'd1, a_pos);
        load_reg(5'd2, a_neg);
        issue_word(itype_word(OPC_ADDIU, 5'd1, 5'd3, 16'($random(seed))));
        issue_word(itype_word(OPC_ANDI, 5'd2, 5'd4, 16'($random(seed))));
        issue_word(itype_word(OPC_ORI, 5'd1, 5'd5, 16'($random(seed))));
        issue_word(itype_word(OPC_XORI, 5'd2, 5'd6, 16'($random(seed))));
        issue_word(itype_word(OPC_LUI, 5'd0, 5'd7, 16'($random(seed))));
        issue_word(itype_word(OPC_SLTI, 5'd1, 5'd8, 16'h8000 | 16'($random(seed))));
        issue_word(itype_word(OPC_SLTIU, 5'd1, 5'd9, 16'h8000 | 16'($random(seed))));
        issue_word(itype_word(OPC_SLTI, 5'd2, 5'd10, 16'h7fff & 16'($random(seed))));
        issue_word(itype_word(OPC_SLTIU, 5'd2, 5'd11, 16'h7fff & 16'($random(seed))));
        for (int r = 1; r < 12; r++)
            check_reg(5'(r));
        report_test();

        start_test("register ops");
        for (int i = 0; i < 4; i++)
            load_reg(5'(10 + i), $random(seed));
        for (int i = 0; i < 11; i++) begin
            rs = 5'(10 + ($random(seed) & 3));
            rt = 5'(10 + ($random(seed) & 3));
            sh = (rfns[i] <= FN_SRA) ? 5'($random(seed)) : 5'd0;
            issue_word(rtype_word(rfns[i], rs, rt, 5'(14 + i), sh));
        end
        for (int r = 10; r < 25; r++)
            check_reg(5'(r));
        report_test();

        start_test("dependent chain");
        load_reg(5'd1, $random(seed));
        load_reg(5'd2, $random(seed));
        issue_word(rtype_word(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
        issue_word(rtype_word(FN_SUBU, 5'd3, 5'd1, 5'd4, 5'd0));
        issue_word(itype_word(OPC_XORI, 5'd4, 5'd4, 16'($random(seed))));
        issue_word(rtype_word(FN_SLL, 5'd0, 5'd4, 5'd5, 5'd3));
        issue_word(rtype_word(FN_SRA, 5'd0, 5'd5, 5'd6, 5'd7));
        issue_word(rtype_word(FN_NOR, 5'd6, 5'd3, 5'd7, 5'd0));
        issue_word(rtype_word(FN_SLT, 5'd7, 5'd6, 5'd8, 5'd0));
        issue_word(itype_word(OPC_ADDIU, 5'd8, 5'd8, 16'($random(seed))));
        for (int r = 1; r < 9; r++)
            check_reg(5'(r));
        report_test();

        start_test("zero register");
        issue_word(itype_word(OPC_ADDIU, 5'd1, 5'd0, 16'h007b));
        issue_word(itype_word(OPC_LUI, 5'd0, 5'd0, 16'hffff));
        issue_word(rtype_word(FN_NOR, 5'd1, 5'd2, 5'd0, 5'd0));
        check_reg(5'd0);
        report_test();

        start_test("exceptions");
        clear_status();
        issue_word(itype_word(6'h3f, 5'd1, 5'd3, 16'($random(seed))));
        issue_word(rtype_word(6'h3f, 5'd1, 5'd2, 5'd4, 5'd0));
        issue_word(itype_word(OPC_BEQ, 5'd1, 5'd5, 16'h0010));
        check_status();
        for (int r = 1; r < 6; r++)
            check_reg(5'(r));
        clear_status();
        load_reg(5'd1, 32'h7fff_ffff);
        issue_word(itype_word(OPC_ADDI, 5'd1, 5'd2, 16'h0001));
        issue_word(itype_word(OPC_ADDIU, 5'd1, 5'd3, 16'h0001));
        check_reg(5'd2);
        check_reg(5'd3);
        check_status();
        report_test();

        start_test("retired count");
        clear_status();
        for (int i = 0; i < 6; i++)
            issue_word(itype_word(OPC_ADDIU, 5'd1, 5'(20 + i), 16'($random(seed))));
        check_status();
        clear_status();
        check_status();
        report_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && !timed_out)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_exec.f
+incdir+include
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/rtype_decoder.sv
hw/main_decoder.sv
hw/exec_alu.sv
hw/reg_file.sv
hw/stage_reg.sv
hw/apb_host_port.sv
hw/mips_exec.sv
bench/tb_mips_exec.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the mips_exec testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mips_exec.f --top-module tb_mips_exec \
    --Mdir obj_dir -o tb_mips_exec

out=$(./obj_dir/tb_mips_exec)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi
